// ==== src.f ====
design/bus_pkg.sv
design/mapper_pkg.sv
design/region_decoder.sv
design/dtack_gen.sv
design/bus_grant.sv
design/mapper_regs.sv
design/mapper_top.sv
bench/tb_mapper.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run; the log decides pass or fail
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mapper -f src.f \
    -o tb_mapper > build.log 2>&1 && \
    ./obj_dir/tb_mapper > sim.log 2>&1 || { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

// ==== bench/tb_mapper.sv ====
// directed testbench for the memory mapper top level
// each test is a task, a watchdog bounds the run, summary at the end

`timescale 1ns/1ps

module tb_mapper;
    import mapper_pkg::*;

    localparam int clk_period      = 100;
    localparam int num_tests       = 5;
    localparam int watchdog_cycles = num_tests * 200;

    logic        clk;
    logic        rst;
    logic        cpu_cen;
    logic        bus_cs;
    logic        bus_busy;
    logic [23:1] addr;
    logic [15:0] cpu_dout;
    logic [1:0]  cpu_dsn;
    logic        cpu_asn;
    logic        cpu_rnw;
    logic [2:0]  cpu_fc;
    logic        cpu_bgn;
    logic        cpu_brn;
    logic        cpu_bgackn;
    logic        cpu_dtackn;
    logic        cpu_haltn;
    logic [23:1] addr_out;
    logic [1:0]  bus_dsn;
    logic        bus_asn;
    logic        bus_rnw;
    logic [15:0] bus_dout;
    logic [15:0] bus_din;
    logic [7:0]  active;
    logic        sndmap_wr;
    logic        sndmap_rd;
    logic [7:0]  sndmap_din;
    logic [7:0]  sndmap_dout;
    logic        sndmap_pbf;
    logic        mcu_wr;
    logic [4:0]  mcu_addr;
    logic [7:0]  mcu_dout;
    logic [7:0]  mcu_din;
    logic        mcu_snd_intn;

    integer      seed = 32'h97b3;
    int          errors = 0;
    int          failed_tests = 0;
    logic        cen_seen;          // cpu_cen as the DUT saw it at the last edge
    logic [7:0]  win_cfg_m [0:7];   // model of the window registers
    logic [7:0]  win_base_m [0:7];

    mapper_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired, the tests did not finish in time");
        $display("Verification failed");
        $finish;
    end

    // one clock, then drive 10 ns later; cpu_cen pulses every other cycle
    task automatic next_cycle();
        @(posedge clk);
        cen_seen = cpu_cen;
        #10;
        cpu_cen = ~cpu_cen;
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s done, no errors", name);
        end else begin
            failed_tests++;
            $display("test %s done, %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic mcu_write(input logic [4:0] a, input logic [7:0] d);
        mcu_addr = a;
        mcu_dout = d;
        mcu_wr   = 1'b1;
        next_cycle();
        mcu_wr   = 1'b0;
        mcu_addr = 5'd0;   // keep off address 3 so the sound irq stays
        next_cycle();
    endtask

    task automatic mcu_read(input logic [4:0] a, output logic [7:0] d);
        mcu_addr = a;
        next_cycle();
        d = mcu_din;
        mcu_addr = 5'd0;
    endtask

    task automatic program_window(input int r, input logic [1:0] size, input logic [1:0] wt,
                                  input logic [7:0] base);
        mcu_write(reg_win_base + 5'(2 * r), {4'h0, wt, size});
        mcu_write(reg_win_base + 5'(2 * r + 1), base);
        win_cfg_m[r]  = {4'h0, wt, size};
        win_base_m[r] = base;
    endtask

    // size codes compare 8, 7, 5 or 3 upper address bits, lowest window wins
    function automatic logic [7:0] expected_active(input logic [23:0] a);
        int         bits;
        logic [7:0] mask;
        for (int r = 0; r < 8; r++) begin
            case (win_cfg_m[r][1:0])
                2'd0:    bits = 8;
                2'd1:    bits = 7;
                2'd2:    bits = 5;
                default: bits = 3;
            endcase
            mask = 8'hff << (8 - bits);
            if ((a[23:16] & mask) == (win_base_m[r] & mask)) return 8'(1 << r);
        end
        return 8'h00;
    endfunction

    task automatic check_decode(input logic [23:0] a, input logic [2:0] fc);
        logic [7:0] exp;
        addr   = a[23:1];
        cpu_fc = fc;
        next_cycle();
        exp = (fc == 3'b111) ? 8'h00 : expected_active(a);
        check_equal("active", active, exp);
        check_equal("none", none_seen(), (expected_active(a) == 8'h00) && fc != 3'b111);
        cpu_fc = 3'b000;
    endtask

    function automatic logic none_seen();
        return u_dut.none;
    endfunction

    // cpu read; optional busy phase first, then cpu_cen pulses until dtack
    task automatic cpu_read_wait(input logic [23:0] a, input int exp_pulses,
                                 input int hold_cycles);
        int pulses;
        int n;
        addr     = a[23:1];
        cpu_rnw  = 1'b1;
        cpu_asn  = 1'b0;
        cpu_dsn  = 2'b00;
        bus_cs   = 1'b1;
        bus_busy = hold_cycles > 0;
        for (int i = 0; i < hold_cycles; i++) begin
            next_cycle();
            check_equal("cpu_dtackn while busy", cpu_dtackn, 1'b1);
        end
        bus_busy = 1'b0;
        pulses = 0;
        n = 0;
        do begin
            next_cycle();
            if (cen_seen) pulses++;
            n++;
        end while (cpu_dtackn && n < 20);
        if (cpu_dtackn) begin
            $display("cpu_dtackn never went low on a cpu read");
            errors++;
        end else begin
            check_equal("cpu_cen pulses to dtack", pulses, exp_pulses);
        end
        cpu_asn = 1'b1;
        cpu_dsn = 2'b11;
        bus_cs  = 1'b0;
        next_cycle();
        check_equal("cpu_dtackn after strobe end", cpu_dtackn, 1'b1);
    endtask

    // one mcu command through request, grant, access and release
    task automatic mcu_bus_cycle(input logic is_read, input logic [23:1] exp_addr,
                                 input logic [15:0] exp_data);
        int n;
        mcu_write(reg_cmd, is_read ? 8'h02 : 8'h01);
        n = 0;
        while (cpu_brn && n < 20) begin
            next_cycle();
            n++;
        end
        if (cpu_brn) begin
            $display("cpu_brn did not fall after the bus command");
            errors++;
        end
        cpu_bgn = 1'b0;
        n = 0;
        while (bus_asn && n < 20) begin
            next_cycle();
            n++;
        end
        if (bus_asn) begin
            $display("the mcu access never drove bus_asn low");
            errors++;
        end else begin
            check_equal("cpu_bgackn", cpu_bgackn, 1'b0);
            check_equal("bus_rnw", bus_rnw, is_read);
            check_equal("bus_dsn", bus_dsn, 2'b00);
            check_equal("addr_out", addr_out, exp_addr);
            if (!is_read) check_equal("bus_din", bus_din, exp_data);
        end
        n = 0;
        while (!cpu_bgackn && n < 40) begin
            next_cycle();
            n++;
        end
        if (!cpu_bgackn) begin
            $display("cpu_bgackn was not released at the end of the mcu cycle");
            errors++;
        end
        cpu_bgn = 1'b1;
        next_cycle();
    endtask

    task automatic test_reset_defaults();
        int         e0;
        logic [7:0] d;
        e0 = errors;
        check_equal("cpu_brn", cpu_brn, 1'b1);
        check_equal("cpu_bgackn", cpu_bgackn, 1'b1);
        check_equal("cpu_dtackn", cpu_dtackn, 1'b1);
        check_equal("cpu_haltn", cpu_haltn, 1'b1);
        check_equal("mcu_snd_intn", mcu_snd_intn, 1'b1);
        check_equal("sndmap_pbf", sndmap_pbf, 1'b0);
        mcu_read(5'd0, d);
        check_equal("data_hi readback", d, 8'h00);
        mcu_read(5'd1, d);
        check_equal("data_lo readback", d, 8'h00);
        report_test("reset_defaults", e0);
    endtask

    task automatic test_window_decode();
        int e0;
        e0 = errors;
        program_window(0, 2'd0, 2'd0, 8'h24);   // 64k at 0x240000
        program_window(1, 2'd2, 2'd1, 8'h20);   // 512k at 0x200000
        program_window(2, 2'd3, 2'd2, 8'h20);   // 2m at 0x200000
        check_decode(24'h241234, 3'b000);       // all three overlap
        check_decode(24'h210000, 3'b000);
        check_decode(24'h2a0000, 3'b000);
        check_decode(24'h500000, 3'b000);       // outside everything
        check_decode(24'h002344, 3'b000);       // unprogrammed windows sit at zero
        check_decode(24'h241234, 3'b111);       // interrupt acknowledge
        report_test("window_decode", e0);
    endtask

    task automatic test_wait_states();
        int e0;
        e0 = errors;
        cpu_read_wait(24'h241234, 1, 0);
        cpu_read_wait(24'h210000, 2, 0);
        cpu_read_wait(24'h2a0000, 3, 0);
        cpu_read_wait(24'h241234, 1, 8);        // back-pressure
        report_test("wait_states", e0);
    endtask

    task automatic test_sound_path();
        int         e0;
        logic [7:0] b;
        logic [7:0] v;
        logic [7:0] d;
        e0 = errors;
        b = 8'($random(seed));
        v = 8'($random(seed));
        sndmap_din = b;
        sndmap_wr  = 1'b1;
        next_cycle();
        sndmap_wr  = 1'b0;
        check_equal("mcu_snd_intn after latch", mcu_snd_intn, 1'b0);
        mcu_read(5'd3, d);
        check_equal("sound latch readback", d, b);
        check_equal("mcu_snd_intn after read", mcu_snd_intn, 1'b1);
        mcu_write(reg_sound, v);
        check_equal("sndmap_pbf after write", sndmap_pbf, 1'b1);
        check_equal("sndmap_dout", sndmap_dout, v);
        sndmap_rd = 1'b1;
        next_cycle();
        sndmap_rd = 1'b0;
        check_equal("sndmap_pbf after read", sndmap_pbf, 1'b0);
        report_test("sound_path", e0);
    endtask

    task automatic test_mcu_bus();
        int          e0;
        logic [15:0] wdata;
        logic [15:0] rdata;
        logic [7:0]  d;
        e0 = errors;
        wdata = 16'($random(seed));
        rdata = 16'($random(seed));
        mcu_write(reg_data_hi, wdata[15:8]);
        mcu_write(reg_data_lo, wdata[7:0]);
        mcu_write(reg_wr_addr, 8'h1a);          // address bytes, msb first
        mcu_write(reg_wr_addr + 5'd1, 8'h2b);
        mcu_write(reg_wr_addr + 5'd2, 8'h3c);
        mcu_bus_cycle(1'b0, {7'h1a, 8'h2b, 8'h3c}, wdata);
        mcu_write(reg_rd_addr, 8'h05);
        mcu_write(reg_rd_addr + 5'd1, 8'h67);
        mcu_write(reg_rd_addr + 5'd2, 8'h88);
        bus_dout = rdata;
        mcu_bus_cycle(1'b1, {7'h05, 8'h67, 8'h88}, 16'h0000);
        mcu_read(5'd0, d);
        check_equal("read data_hi", d, rdata[15:8]);
        mcu_read(5'd1, d);
        check_equal("read data_lo", d, rdata[7:0]);
        report_test("mcu_bus", e0);
    endtask

    initial begin
        rst = 1'b1;
        cpu_cen = 1'b0;
        bus_cs = 1'b0;
        bus_busy = 1'b0;
        addr = '0;
        cpu_dout = 16'h0000;
        cpu_dsn = 2'b11;
        cpu_asn = 1'b1;
        cpu_rnw = 1'b1;
        cpu_fc = 3'b000;
        cpu_bgn = 1'b1;
        bus_dout = 16'h0000;
        sndmap_wr = 1'b0;
        sndmap_rd = 1'b0;
        sndmap_din = 8'h00;
        mcu_wr = 1'b0;
        mcu_addr = 5'd0;
        mcu_dout = 8'h00;
        for (int r = 0; r < 8; r++) begin
            win_cfg_m[r]  = 8'h00;
            win_base_m[r] = 8'h00;
        end
        repeat (4) next_cycle();
        rst = 1'b0;
        next_cycle();

        test_reset_defaults();
        test_window_decode();
        test_wait_states();
        test_sound_path();
        test_mcu_bus();

        $display("%0d tests, %0d failed, %0d errors", num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== design/mapper_top.sv ====
// memory mapper top level, decoder, DTACK, bus grant and registers
// the external bus is switched between cpu and mcu while the mcu owns it

`timescale 1ns/1ps

module mapper_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cpu_cen,
    input  logic                               bus_cs,
    input  logic                               bus_busy,
    // 68000 side
    input  logic [23:1]                        addr,
    input  logic [15:0]                        cpu_dout,
    input  logic [1:0]                         cpu_dsn,
    input  logic                               cpu_asn,
    input  logic                               cpu_rnw,
    input  logic [2:0]                         cpu_fc,
    input  logic                               cpu_bgn,
    output logic                               cpu_brn,
    output logic                               cpu_bgackn,
    output logic                               cpu_dtackn,
    output logic                               cpu_haltn,
    // external bus
    output logic [23:1]                        addr_out,
    output logic [1:0]                         bus_dsn,
    output logic                               bus_asn,
    output logic                               bus_rnw,
    input  logic [15:0]                        bus_dout,
    output logic [15:0]                        bus_din,
    output logic [bus_pkg::num_regions-1:0]    active,
    // sound cpu
    input  logic                               sndmap_wr,
    input  logic                               sndmap_rd,
    input  logic [7:0]                         sndmap_din,
    output logic [7:0]                         sndmap_dout,
    output logic                               sndmap_pbf,
    // mcu
    input  logic                               mcu_wr,
    input  logic [4:0]                         mcu_addr,
    input  logic [7:0]                         mcu_dout,
    output logic [7:0]                         mcu_din,
    output logic                               mcu_snd_intn
);
    import bus_pkg::*;

    logic [2*num_regions-1:0][7:0] win_cfg;
    dtack_code   wait_code;
    logic        none;
    logic        bus_mcu;
    logic        bus_rq;
    logic        mcu_asn;
    logic        mcu_rnw;
    logic [23:1] mcu_addr_out;
    logic [15:0] mcu_data;

    // bus owner select
    assign addr_out = bus_mcu ? mcu_addr_out : addr;
    assign bus_asn  = bus_mcu ? mcu_asn : cpu_asn;
    assign bus_rnw  = bus_mcu ? mcu_rnw : cpu_rnw;
    assign bus_dsn  = bus_mcu ? 2'b00 : cpu_dsn;    // mcu always moves words
    assign bus_din  = bus_mcu ? mcu_data : cpu_dout;

    region_decoder u_decoder (
        .addr_out (addr_out), .cpu_fc (cpu_fc), .win_cfg (win_cfg),
        .active (active), .none (none), .wait_code (wait_code)
    );

    dtack_gen u_dtack (
        .clk (clk), .rst (rst), .cpu_cen (cpu_cen), .cpu_asn (cpu_asn),
        .cpu_dsn (cpu_dsn), .bus_cs (bus_cs), .bus_busy (bus_busy),
        .wait_code (wait_code), .cpu_dtackn (cpu_dtackn)
    );

    bus_grant u_grant (
        .clk (clk), .rst (rst), .cpu_cen (cpu_cen), .bus_rq (bus_rq),
        .cpu_bgn (cpu_bgn), .cpu_asn (cpu_asn), .cpu_brn (cpu_brn),
        .cpu_bgackn (cpu_bgackn), .bus_mcu (bus_mcu)
    );

    mapper_regs u_regs (
        .clk (clk), .rst (rst),
        .mcu_wr (mcu_wr), .mcu_addr (mcu_addr), .mcu_dout (mcu_dout), .mcu_din (mcu_din),
        .cpu_asn (cpu_asn), .cpu_rnw (cpu_rnw), .cpu_dsn (cpu_dsn[0]),
        .addr_sel (addr[5:1]), .cpu_dout (cpu_dout[7:0]), .none (none),
        .sndmap_wr (sndmap_wr), .sndmap_rd (sndmap_rd), .sndmap_din (sndmap_din),
        .sndmap_dout (sndmap_dout), .sndmap_pbf (sndmap_pbf), .mcu_snd_intn (mcu_snd_intn),
        .bus_mcu (bus_mcu), .bus_busy (bus_busy), .bus_dout (bus_dout),
        .bus_rq (bus_rq), .mcu_asn (mcu_asn), .mcu_rnw (mcu_rnw),
        .mcu_addr_out (mcu_addr_out), .mcu_data (mcu_data),
        .cpu_haltn (cpu_haltn), .win_cfg (win_cfg)
    );

endmodule

// ==== design/mapper_regs.sv ====
// 32 byte register file written by the cpu or the mcu, sound latch and flags,
// mcu readback and the fsm that runs one mcu owned bus cycle per command

`timescale 1ns/1ps

module mapper_regs (
    input  logic                                   clk,
    input  logic                                   rst,
    // mcu port
    input  logic                                   mcu_wr,
    input  logic [4:0]                             mcu_addr,
    input  logic [7:0]                             mcu_dout,
    output logic [7:0]                             mcu_din,
    // cpu register writes
    input  logic                                   cpu_asn,
    input  logic                                   cpu_rnw,
    input  logic                                   cpu_dsn,      // lower data strobe
    input  logic [4:0]                             addr_sel,
    input  logic [7:0]                             cpu_dout,
    input  logic                                   none,
    // sound cpu
    input  logic                                   sndmap_wr,
    input  logic                                   sndmap_rd,
    input  logic [7:0]                             sndmap_din,
    output logic [7:0]                             sndmap_dout,
    output logic                                   sndmap_pbf,
    output logic                                   mcu_snd_intn,
    // mcu bus cycle
    input  logic                                   bus_mcu,
    input  logic                                   bus_busy,
    input  logic [15:0]                            bus_dout,
    output logic                                   bus_rq,
    output logic                                   mcu_asn,
    output logic                                   mcu_rnw,
    output logic [23:1]                            mcu_addr_out,
    output logic [15:0]                            mcu_data,
    output logic                                   cpu_haltn,
    output logic [2*bus_pkg::num_regions-1:0][7:0] win_cfg
);
    import bus_pkg::*;
    import mapper_pkg::*;

    logic [7:0]  regs [0:31];
    logic [7:0]  snd_latch;
    logic        cpu_sel;        // cpu may write until the mcu writes once
    logic        mcu_wr_l;
    logic        cpu_wr_l;
    logic        cpu_wren;
    logic        mcu_edge;
    logic        cpu_edge;
    logic        wr_en;
    logic [4:0]  reg_sel;
    logic [7:0]  reg_din;
    logic        cmd_valid;
    mcu_state    state;
    bus_cmd      cmd_q;
    logic [2:0]  cnt;            // access length counter
    logic [23:1] rd_bus_addr;
    logic [23:1] wr_bus_addr;

    // cpu reaches the registers only through unmapped write cycles
    assign cpu_wren = !cpu_asn && !cpu_dsn && !cpu_rnw && none;
    assign mcu_edge = mcu_wr && !mcu_wr_l;
    assign cpu_edge = cpu_wren && !cpu_wr_l && cpu_sel;
    assign wr_en    = mcu_edge || cpu_edge;
    assign reg_sel  = mcu_edge ? mcu_addr : addr_sel;   // mcu first on a clash
    assign reg_din  = mcu_edge ? mcu_dout : cpu_dout;

    assign cmd_valid = reg_din[1:0] == cmd_write || reg_din[1:0] == cmd_read;

    assign rd_bus_addr = {regs[reg_rd_addr][6:0], regs[reg_rd_addr + 5'd1],
                          regs[reg_rd_addr + 5'd2]};
    assign wr_bus_addr = {regs[reg_wr_addr][6:0], regs[reg_wr_addr + 5'd1],
                          regs[reg_wr_addr + 5'd2]};

    assign mcu_addr_out = cmd_q == cmd_read ? rd_bus_addr : wr_bus_addr;
    assign mcu_rnw      = cmd_q != cmd_write;
    assign mcu_data     = {regs[reg_data_hi], regs[reg_data_lo]};
    assign bus_rq       = state == st_request || state == st_access;
    assign cpu_haltn    = ~regs[reg_ctrl][1];
    assign sndmap_dout  = regs[reg_sound];

    for (genvar g = 0; g < 2*num_regions; g++) begin : g_win
        assign win_cfg[g] = regs[reg_win_base + 5'(g)];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            cpu_sel    <= 1'b1;
            mcu_wr_l   <= 1'b0;
            cpu_wr_l   <= 1'b0;
            sndmap_pbf <= 1'b0;
            state      <= st_idle;
            cmd_q      <= cmd_none;
            cnt        <= '0;
            mcu_asn    <= 1'b1;
        end else begin
            mcu_wr_l <= mcu_wr;
            cpu_wr_l <= cpu_wren;
            if (mcu_wr) cpu_sel <= 1'b0;   // sticky until reset
            if (wr_en) begin
                regs[reg_sel] <= reg_din;
                if (reg_sel == reg_sound) sndmap_pbf <= 1'b1;
                if (reg_sel == reg_cmd && state == st_idle && cmd_valid) begin
                    cmd_q <= bus_cmd'(reg_din[1:0]);
                    state <= st_request;
                end
            end
            if (sndmap_rd) sndmap_pbf <= 1'b0;
            case (state)
                st_idle: ;
                st_request: begin
                    if (bus_mcu) begin   // bgack is out, start the access
                        state   <= st_access;
                        cnt     <= access_cycles - 3'd1;
                        mcu_asn <= 1'b0;
                    end
                end
                st_access: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 3'd1;
                    end else if (!bus_busy) begin
                        mcu_asn <= 1'b1;
                        state   <= st_release;
                        if (cmd_q == cmd_read) begin
                            {regs[reg_data_hi], regs[reg_data_lo]} <= bus_dout;
                        end
                    end
                end
                st_release: if (!bus_mcu) state <= st_idle;   // wait for bgack to clear
            endcase
        end
    end

    // a latch read is address 3 selected with mcu_wr low
    // a new sound byte wins over a read in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mcu_snd_intn <= 1'b1;
        end else begin
            if (mcu_addr[1:0] == 2'd3 && !mcu_wr) mcu_snd_intn <= 1'b1;
            if (sndmap_wr) mcu_snd_intn <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sndmap_wr) snd_latch <= sndmap_din;
    end

    // readback, one cycle after the address
    always_ff @(posedge clk) begin
        case (mcu_addr[1:0])
            2'd0: mcu_din <= regs[reg_data_hi];
            2'd1: mcu_din <= regs[reg_data_lo];
            2'd2: mcu_din <= {1'b0, bus_rq, sndmap_pbf, 3'b000, cpu_haltn, 1'b0};
            2'd3: mcu_din <= snd_latch;
        endcase
    end

    // the mcu strobe only reaches the bus while the grant is held
    a_asn_owned: assert property (@(posedge clk) disable iff (rst)
        !mcu_asn |-> bus_mcu)
        else $error("mapper_regs: mcu address strobe without bus ownership");

endmodule

// ==== design/bus_grant.sv ====
// 68000 bus arbitration for mcu owned cycles
// BR out, wait for BG with AS idle, hold BGACK until the request drops

`timescale 1ns/1ps

module bus_grant (
    input  logic clk,
    input  logic rst,
    input  logic cpu_cen,
    input  logic bus_rq,
    input  logic cpu_bgn,
    input  logic cpu_asn,
    output logic cpu_brn,
    output logic cpu_bgackn,
    output logic bus_mcu
);
    typedef enum logic [1:0] {
        gr_idle,
        gr_request,
        gr_own
    } grant_state;

    grant_state state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= gr_idle;
        end else begin
            case (state)
                gr_idle: if (bus_rq) state <= gr_request;
                gr_request: begin
                    if (!bus_rq) begin
                        state <= gr_idle;   // request withdrawn
                    end else if (cpu_cen && !cpu_bgn && cpu_asn) begin
                        state <= gr_own;    // cpu finished its cycle
                    end
                end
                gr_own: if (!bus_rq) state <= gr_idle;
                default: state <= gr_idle;
            endcase
        end
    end

    assign cpu_brn    = state != gr_request;   // BR drops once BGACK is out
    assign cpu_bgackn = state != gr_own;
    assign bus_mcu    = state == gr_own;

    a_grant_first: assert property (@(posedge clk) disable iff (rst)
        $fell(cpu_bgackn) |-> $past(!cpu_bgn))
        else $error("bus_grant: bgack asserted without a bus grant");

endmodule

// ==== design/dtack_gen.sv ====
// DTACK for cpu cycles, base acknowledge on the first cpu_cen
// then one or two more cpu_cen pulses depending on the window wait code

`timescale 1ns/1ps

module dtack_gen (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_cen,
    input  logic               cpu_asn,
    input  logic [1:0]         cpu_dsn,
    input  logic               bus_cs,
    input  logic               bus_busy,
    input  bus_pkg::dtack_code wait_code,
    output logic               cpu_dtackn
);
    import bus_pkg::*;

    logic dtackn1;   // base acknowledge
    logic dtackn2;
    logic dtackn3;
    logic hold;

    assign hold = bus_cs && bus_busy;   // memory not ready yet

    always_ff @(posedge clk) begin
        if (rst || cpu_asn) begin
            dtackn1 <= 1'b1;
            dtackn2 <= 1'b1;
            dtackn3 <= 1'b1;
        end else if (cpu_cen) begin
            if (cpu_dsn != 2'b11 && !hold) begin
                dtackn1 <= 1'b0;
            end
            dtackn2 <= dtackn1;   // delay line moves only on cpu_cen
            dtackn3 <= dtackn2;
        end
    end

    always_comb begin
        case (wait_code)
            wait_1:  cpu_dtackn = dtackn1;
            wait_2:  cpu_dtackn = dtackn2;
            default: cpu_dtackn = dtackn3;   // code 3 too
        endcase
    end

    // dtack clears one cycle after the strobe goes away and stays clear
    a_dtack_idle: assert property (@(posedge clk) disable iff (rst)
        cpu_asn && $past(cpu_asn) |-> cpu_dtackn)
        else $error("dtack_gen: dtack low with address strobe high");

endmodule

// ==== design/region_decoder.sv ====
// compares the bus address against the eight programmed windows
// purely combinational, lowest window index wins

`timescale 1ns/1ps

module region_decoder (
    input  logic [23:1]                           addr_out,
    input  logic [2:0]                            cpu_fc,
    input  logic [2*bus_pkg::num_regions-1:0][7:0] win_cfg,
    output logic [bus_pkg::num_regions-1:0]       active,
    output logic                                  none,
    output bus_pkg::dtack_code                    wait_code
);
    import bus_pkg::*;

    logic [num_regions-1:0] hit;
    logic [num_regions-1:0] lowest;
    logic                   intack;

    // one window against the address, cfg[1:0] gives the size
    function automatic logic win_hit(input logic [7:0] cfg, input logic [7:0] base,
                                     input logic [23:1] a);
        case (size_code'(cfg[1:0]))
            size_64k:  return a[23:16] == base;
            size_128k: return a[23:17] == base[7:1];
            size_512k: return a[23:19] == base[7:3];
            size_2m:   return a[23:21] == base[7:5];
        endcase
    endfunction

    always_comb begin
        for (int r = 0; r < num_regions; r++) begin
            hit[r] = win_hit(win_cfg[2*r], win_cfg[2*r+1], addr_out);
        end
    end

    assign intack = cpu_fc == fc_intack;
    assign lowest = hit & (~hit + 1'b1);   // keeps the lowest set bit only

    assign active = intack ? '0 : lowest;
    assign none   = (hit == '0) && !intack;

    // wait bits of the winning window
    always_comb begin
        wait_code = wait_1;
        for (int r = 0; r < num_regions; r++) begin
            if (active[r]) begin
                wait_code = dtack_code'(win_cfg[2*r][3:2]);
            end
        end
    end

endmodule

// ==== design/mapper_pkg.sv ====
// register map of the mapper and the encodings of the MCU driven bus cycle
// imported by the register block

package mapper_pkg;

    // register indices
    localparam logic [4:0] reg_data_hi = 5'd0;
    localparam logic [4:0] reg_data_lo = 5'd1;
    localparam logic [4:0] reg_ctrl    = 5'd2;   // bit 1 halts the cpu
    localparam logic [4:0] reg_sound   = 5'd3;
    localparam logic [4:0] reg_cmd     = 5'd5;

    // bus addresses take three registers each, msb first
    localparam logic [4:0] reg_rd_addr = 5'd7;   // 7..9
    localparam logic [4:0] reg_wr_addr = 5'd10;  // 10..12

    // 16 + 2r is size/wait of region r, 17 + 2r its base
    localparam logic [4:0] reg_win_base = 5'd16;

    // minimum length of an mcu bus access in clk cycles
    localparam logic [2:0] access_cycles = 3'd7;

    // values written to reg_cmd
    typedef enum logic [1:0] {
        cmd_none  = 2'b00,
        cmd_write = 2'b01,
        cmd_read  = 2'b10
    } bus_cmd;

    // mcu bus cycle sequence
    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_access,
        st_release
    } mcu_state;

endpackage

// ==== design/bus_pkg.sv ====
// 68000 bus side definitions shared by the decoder, the DTACK logic and the top
// imported inside module bodies, scoped names in port lists

package bus_pkg;

    localparam int num_regions = 8;    // decoded windows

    // window size, selects how many address bits are compared
    typedef enum logic [1:0] {
        size_64k  = 2'd0,   // addr[23:16]
        size_128k = 2'd1,   // addr[23:17]
        size_512k = 2'd2,   // addr[23:19]
        size_2m   = 2'd3    // addr[23:21]
    } size_code;

    // wait states before DTACK, code 3 runs as three cycles
    typedef enum logic [1:0] {
        wait_1 = 2'd0,
        wait_2 = 2'd1,
        wait_3 = 2'd2
    } dtack_code;

    // interrupt acknowledge function code
    localparam logic [2:0] fc_intack = 3'b111;

endpackage
